/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

        typedef enum logic [6:0] {
                opc_op        = 7'b0110011,
                opc_op_32     = 7'b0111011,
                opc_op_imm    = 7'b0010011,
                opc_op_imm_32 = 7'b0011011,
                opc_load      = 7'b0000011,
                opc_store     = 7'b0100011,
                opc_branch    = 7'b1100011,
                opc_jal       = 7'b1101111,
                opc_jalr      = 7'b1100111,
                opc_lui       = 7'b0110111,
                opc_auipc     = 7'b0010111,
                opc_system    = 7'b1110011
        } opcode_e;

        typedef struct packed {
                logic [6:0] funct7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                opcode_e    opcode;
        } r_fields_t;

        typedef struct packed {
                logic [11:0] imm12;
                logic [4:0]  rs1;
                logic [2:0]  funct3;
                logic [4:0]  rd;
                opcode_e     opcode;
        } i_fields_t;

        typedef union packed {
                r_fields_t r;
                i_fields_t i;
        } inst_t;

        localparam logic [2:0] f3_add_sub = 3'b000;
        localparam logic [2:0] f3_sll     = 3'b001;
        localparam logic [2:0] f3_slt     = 3'b010;
        localparam logic [2:0] f3_sltu    = 3'b011;
        localparam logic [2:0] f3_xor     = 3'b100;
        localparam logic [2:0] f3_srl_sra = 3'b101;
        localparam logic [2:0] f3_or      = 3'b110;
        localparam logic [2:0] f3_and     = 3'b111;

        // M extension subset that the core implements
        localparam logic [2:0] f3_mul  = 3'b000;
        localparam logic [2:0] f3_div  = 3'b100;
        localparam logic [2:0] f3_divu = 3'b101;
        localparam logic [2:0] f3_rem  = 3'b110;
        localparam logic [2:0] f3_remu = 3'b111;

        localparam logic [2:0] f3_beq  = 3'b000;
        localparam logic [2:0] f3_bne  = 3'b001;
        localparam logic [2:0] f3_blt  = 3'b100;
        localparam logic [2:0] f3_bge  = 3'b101;
        localparam logic [2:0] f3_bltu = 3'b110;
        localparam logic [2:0] f3_bgeu = 3'b111;

        localparam logic [2:0] f3_mem_b  = 3'b000;
        localparam logic [2:0] f3_mem_h  = 3'b001;
        localparam logic [2:0] f3_mem_w  = 3'b010;
        localparam logic [2:0] f3_mem_d  = 3'b011;
        localparam logic [2:0] f3_mem_bu = 3'b100;
        localparam logic [2:0] f3_mem_hu = 3'b101;
        localparam logic [2:0] f3_mem_wu = 3'b110;

        localparam logic [6:0] f7_base   = 7'b0000000;
        localparam logic [6:0] f7_alt    = 7'b0100000;
        localparam logic [6:0] f7_muldiv = 7'b0000001;

        localparam logic [11:0] ebreak_imm = 12'h001;

endpackage

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

        typedef enum logic [4:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor,
                alu_sll, alu_srl, alu_sra, alu_lt, alu_ltu,
                alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw,
                alu_mul, alu_div, alu_divu, alu_rem, alu_remu,
                alu_mulw, alu_divw, alu_divuw, alu_remw, alu_remuw
        } alu_sel_e;

        typedef enum logic [1:0] {
                alu_a_rs1,
                alu_a_pc,
                alu_a_zero
        } alu_a_sel_e;

        typedef enum logic {
                alu_b_rs2,
                alu_b_imm
        } alu_b_sel_e;

        typedef enum logic [2:0] {
                imm_i, imm_s, imm_sb, imm_u, imm_uj
        } imm_sel_e;

        typedef enum logic [2:0] {
                mem_r_b, mem_r_h, mem_r_w, mem_r_d, mem_r_bu, mem_r_hu, mem_r_wu
        } mem_r_sel_e;

        typedef enum logic [1:0] {
                reg_w_alu,
                reg_w_mem,
                reg_w_pc
        } reg_w_sel_e;

        typedef enum logic {
                pc_snpc,      // sequential next pc
                pc_alu
        } pc_sel_e;

        localparam logic [7:0] mem_mask_b = 8'h01;
        localparam logic [7:0] mem_mask_h = 8'h03;
        localparam logic [7:0] mem_mask_w = 8'h0f;
        localparam logic [7:0] mem_mask_d = 8'hff;

        typedef struct packed {
                pc_sel_e    pc_sel;
                imm_sel_e   imm_sel;
                alu_sel_e   alu_sel;
                alu_a_sel_e alu_a_sel;
                alu_b_sel_e alu_b_sel;
                mem_r_sel_e mem_r_sel;
                logic       reg_wen;
                logic       mem_wen;
                logic       mem_ren;
                logic [7:0] mem_mask;
                reg_w_sel_e reg_w_sel;
        } ctrl_t;

        localparam ctrl_t ctrl_idle = '{
                pc_sel:    pc_snpc,
                imm_sel:   imm_i,
                alu_sel:   alu_add,
                alu_a_sel: alu_a_rs1,
                alu_b_sel: alu_b_rs2,
                mem_r_sel: mem_r_b,
                reg_wen:   1'b0,
                mem_wen:   1'b0,
                mem_ren:   1'b0,
                mem_mask:  8'h00,
                reg_w_sel: reg_w_alu
        };

        typedef struct packed {
                logic eq;
                logic lt;
                logic ltu;
        } branch_flags_t;

        typedef struct packed {
                logic  hit;
                ctrl_t ctrl;
        } op_decode_t;

endpackage

/* rtl/alu_op_decode.sv */
`timescale 1ns/100ps

module alu_op_decode (
        input  rv_isa_pkg::inst_t     inst,
        output ctrl_pkg::op_decode_t  dec
);
        import rv_isa_pkg::*;
        import ctrl_pkg::*;

        logic     hit;
        logic     imm_form;
        alu_sel_e alu;

        always_comb begin
                hit = 1'b1;
                alu = alu_add;
                imm_form = (inst.r.opcode == opc_op_imm) || (inst.r.opcode == opc_op_imm_32);
                case (inst.r.opcode)
                opc_op: begin
                        case ({inst.r.funct7, inst.r.funct3})
                        {f7_base, f3_add_sub}:  alu = alu_add;
                        {f7_alt, f3_add_sub}:   alu = alu_sub;
                        {f7_base, f3_sll}:      alu = alu_sll;
                        {f7_base, f3_slt}:      alu = alu_lt;
                        {f7_base, f3_sltu}:     alu = alu_ltu;
                        {f7_base, f3_xor}:      alu = alu_xor;
                        {f7_base, f3_srl_sra}:  alu = alu_srl;
                        {f7_alt, f3_srl_sra}:   alu = alu_sra;
                        {f7_base, f3_or}:       alu = alu_or;
                        {f7_base, f3_and}:      alu = alu_and;
                        {f7_muldiv, f3_mul}:    alu = alu_mul;
                        {f7_muldiv, f3_div}:    alu = alu_div;
                        {f7_muldiv, f3_divu}:   alu = alu_divu;
                        {f7_muldiv, f3_rem}:    alu = alu_rem;
                        {f7_muldiv, f3_remu}:   alu = alu_remu;
                        default:                hit = 1'b0;
                        endcase
                end
                opc_op_32: begin
                        case ({inst.r.funct7, inst.r.funct3})
                        {f7_base, f3_add_sub}:  alu = alu_addw;
                        {f7_alt, f3_add_sub}:   alu = alu_subw;
                        {f7_base, f3_sll}:      alu = alu_sllw;
                        {f7_base, f3_srl_sra}:  alu = alu_srlw;
                        {f7_alt, f3_srl_sra}:   alu = alu_sraw;
                        {f7_muldiv, f3_mul}:    alu = alu_mulw;
                        {f7_muldiv, f3_div}:    alu = alu_divw;
                        {f7_muldiv, f3_divu}:   alu = alu_divuw;
                        {f7_muldiv, f3_rem}:    alu = alu_remw;
                        {f7_muldiv, f3_remu}:   alu = alu_remuw;
                        default:                hit = 1'b0;
                        endcase
                end
                opc_op_imm: begin
                        case (inst.i.funct3)
                        f3_add_sub: alu = alu_add;
                        f3_slt:     alu = alu_lt;
                        f3_sltu:    alu = alu_ltu;
                        f3_xor:     alu = alu_xor;
                        f3_or:      alu = alu_or;
                        f3_and:     alu = alu_and;
                        f3_sll:     hit = (inst.r.funct7[6:1] == f7_base[6:1]); // funct7[0] is shamt[5]
                        f3_srl_sra: begin
                                if (inst.r.funct7[6:1] == f7_alt[6:1])
                                        alu = alu_sra;
                                else
                                        alu = alu_srl;
                                hit = (inst.r.funct7[6:1] == f7_alt[6:1]) ||
                                      (inst.r.funct7[6:1] == f7_base[6:1]);
                        end
                        default:    hit = 1'b0;
                        endcase
                        if (inst.i.funct3 == f3_sll)
                                alu = alu_sll;
                end
                opc_op_imm_32: begin
                        case ({inst.r.funct7, inst.r.funct3})
                        {f7_base, f3_sll}:      alu = alu_sllw;
                        {f7_base, f3_srl_sra}:  alu = alu_srlw;
                        {f7_alt, f3_srl_sra}:   alu = alu_sraw;
                        default: begin
                                alu = alu_addw;
                                hit = (inst.i.funct3 == f3_add_sub); // addiw takes any imm
                        end
                        endcase
                end
                default: hit = 1'b0;
                endcase

                dec = '{hit: 1'b0, ctrl: ctrl_idle};
                if (hit) begin
                        dec.hit = 1'b1;
                        dec.ctrl.alu_sel = alu;
                        dec.ctrl.alu_b_sel = imm_form ? alu_b_imm : alu_b_rs2;
                        dec.ctrl.reg_wen = 1'b1;
                        dec.ctrl.reg_w_sel = reg_w_alu;
                end
        end

endmodule

/* rtl/mem_op_decode.sv */
`timescale 1ns/100ps

module mem_op_decode (
        input  rv_isa_pkg::inst_t     inst,
        output ctrl_pkg::op_decode_t  dec
);
        import rv_isa_pkg::*;
        import ctrl_pkg::*;

        logic       ld_ok;
        logic       st_ok;
        mem_r_sel_e rd_fmt;
        logic [7:0] mask;

        always_comb begin
                ld_ok = (inst.i.opcode == opc_load);
                st_ok = (inst.r.opcode == opc_store);
                rd_fmt = mem_r_b;
                mask = 8'h00;

                case (inst.i.funct3)
                f3_mem_b:  rd_fmt = mem_r_b;
                f3_mem_h:  rd_fmt = mem_r_h;
                f3_mem_w:  rd_fmt = mem_r_w;
                f3_mem_d:  rd_fmt = mem_r_d;
                f3_mem_bu: rd_fmt = mem_r_bu;
                f3_mem_hu: rd_fmt = mem_r_hu;
                f3_mem_wu: rd_fmt = mem_r_wu;
                default:   ld_ok = 1'b0;
                endcase

                case (inst.r.funct3)
                f3_mem_b: mask = mem_mask_b;
                f3_mem_h: mask = mem_mask_h;
                f3_mem_w: mask = mem_mask_w;
                f3_mem_d: mask = mem_mask_d;
                default:  st_ok = 1'b0;   // no unsigned stores
                endcase

                dec = '{hit: 1'b0, ctrl: ctrl_idle};
                if (ld_ok || st_ok) begin
                        dec.hit = 1'b1;
                        dec.ctrl.alu_b_sel = alu_b_imm;   // rs1 + offset
                        dec.ctrl.imm_sel = st_ok ? imm_s : imm_i;
                end
                if (ld_ok) begin
                        dec.ctrl.mem_ren = 1'b1;
                        dec.ctrl.mem_r_sel = rd_fmt;
                        dec.ctrl.reg_wen = 1'b1;
                        dec.ctrl.reg_w_sel = reg_w_mem;
                end
                if (st_ok) begin
                        dec.ctrl.mem_wen = 1'b1;
                        dec.ctrl.mem_mask = mask;
                end
        end

endmodule

/* rtl/flow_op_decode.sv */
`timescale 1ns/100ps

module flow_op_decode (
        input  rv_isa_pkg::inst_t        inst,
        input  ctrl_pkg::branch_flags_t  flags,
        output ctrl_pkg::op_decode_t     dec,
        output logic                     ebreak
);
        import rv_isa_pkg::*;
        import ctrl_pkg::*;

        logic  hit;
        logic  taken;
        ctrl_t c;

        always_comb begin
                hit = 1'b1;
                taken = 1'b0;
                c = ctrl_idle;
                c.alu_b_sel = alu_b_imm;   // every form here adds an immediate
                ebreak = 1'b0;

                case (inst.i.opcode)
                opc_branch: begin
                        case (inst.i.funct3)
                        f3_beq:  taken = flags.eq;
                        f3_bne:  taken = ~flags.eq;
                        f3_blt:  taken = flags.lt;
                        f3_bge:  taken = ~flags.lt;
                        f3_bltu: taken = flags.ltu;
                        f3_bgeu: taken = ~flags.ltu;
                        default: hit = 1'b0;
                        endcase
                        c.imm_sel = imm_sb;
                        c.alu_a_sel = alu_a_pc;
                        if (taken)
                                c.pc_sel = pc_alu;
                end
                opc_jal: begin
                        c.imm_sel = imm_uj;
                        c.alu_a_sel = alu_a_pc;
                        c.pc_sel = pc_alu;
                        c.reg_wen = 1'b1;
                        c.reg_w_sel = reg_w_pc;   // link address
                end
                opc_jalr: begin
                        hit = (inst.i.funct3 == 3'b000);
                        c.pc_sel = pc_alu;
                        c.reg_wen = 1'b1;
                        c.reg_w_sel = reg_w_pc;
                end
                opc_auipc, opc_lui: begin
                        c.imm_sel = imm_u;
                        c.alu_a_sel = (inst.i.opcode == opc_lui) ? alu_a_zero : alu_a_pc;
                        c.reg_wen = 1'b1;
                end
                opc_system: begin
                        hit = 1'b0;   // ebreak leaves on its own port
                        ebreak = (inst.i.imm12 == ebreak_imm) && (inst.i.rs1 == 5'd0) &&
                                 (inst.i.funct3 == 3'b000) && (inst.i.rd == 5'd0);
                end
                default: hit = 1'b0;
                endcase

                dec = hit ? '{hit: 1'b1, ctrl: c} : '{hit: 1'b0, ctrl: ctrl_idle};
        end

endmodule

/* rtl/ctrl_stage_reg.sv */
`timescale 1ns/100ps

module ctrl_stage_reg (
        input  logic                  clk,
        input  logic                  reset,
        input  ctrl_pkg::op_decode_t  alu_dec,
        input  ctrl_pkg::op_decode_t  mem_dec,
        input  ctrl_pkg::op_decode_t  flow_dec,
        input  logic                  ebreak,
        output ctrl_pkg::ctrl_t       ctrl,
        output logic                  ebreak_flag
);
        import ctrl_pkg::*;

        ctrl_t next_ctrl;
        logic  next_flag;

        // opcode sets are disjoint, so the order here is arbitrary
        always_comb begin
                next_ctrl = ctrl_idle;
                next_flag = 1'b0;
                if (alu_dec.hit)
                        next_ctrl = alu_dec.ctrl;
                else if (mem_dec.hit)
                        next_ctrl = mem_dec.ctrl;
                else if (flow_dec.hit)
                        next_ctrl = flow_dec.ctrl;
                else
                        next_flag = 1'b1;   // unknown word traps like ebreak
                if (ebreak) begin
                        next_ctrl = ctrl_idle;
                        next_flag = 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        ctrl <= ctrl_idle;
                        ebreak_flag <= 1'b0;
                end else begin
                        ctrl <= next_ctrl;
                        ebreak_flag <= next_flag;
                end
        end

endmodule

/* rtl/control.sv */
`timescale 1ns/100ps

module control (
        input  logic                     clk,
        input  logic                     reset,
        input  rv_isa_pkg::inst_t        inst,
        input  ctrl_pkg::branch_flags_t  flags,
        output ctrl_pkg::ctrl_t          ctrl,
        output logic                     ebreak_flag
);
        import ctrl_pkg::*;

        op_decode_t alu_dec;
        op_decode_t mem_dec;
        op_decode_t flow_dec;
        logic       ebreak;

        alu_op_decode u_alu_dec (
                .inst (inst),
                .dec  (alu_dec)
        );

        mem_op_decode u_mem_dec (
                .inst (inst),
                .dec  (mem_dec)
        );

        flow_op_decode u_flow_dec (
                .inst   (inst),
                .flags  (flags),
                .dec    (flow_dec),
                .ebreak (ebreak)
        );

        ctrl_stage_reg u_stage (
                .clk         (clk),
                .reset       (reset),
                .alu_dec     (alu_dec),
                .mem_dec     (mem_dec),
                .flow_dec    (flow_dec),
                .ebreak      (ebreak),
                .ctrl        (ctrl),
                .ebreak_flag (ebreak_flag)
        );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
        parameter int half_period  = 4,
        parameter int reset_cycles = 8
) (
        output logic clk,
        output logic reset
);
        initial begin
                clk = 1'b0;
                forever #(half_period) clk = ~clk;
        end

        initial begin
                reset = 1'b1;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;   // released on a falling edge
        end

endmodule

/* verification/control_ref.svh */
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

function automatic inst_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd, input opcode_e opc);
        inst_t w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return w;
endfunction

function automatic inst_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input opcode_e opc);
        inst_t w;
        w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return w;
endfunction

// alu function of a register form or of its 32-bit word variant
function automatic alu_sel_e reg_alu(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic word, output logic ok);
        alu_sel_e op;
        ok = 1'b1;
        op = alu_add;
        case (f7)
        f7_base: begin
                case (f3)
                3'd0: op = word ? alu_addw : alu_add;
                3'd1: op = word ? alu_sllw : alu_sll;
                3'd2: op = alu_lt;
                3'd3: op = alu_ltu;
                3'd4: op = alu_xor;
                3'd5: op = word ? alu_srlw : alu_srl;
                3'd6: op = alu_or;
                default: op = alu_and;
                endcase
                ok = !word || (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
        end
        f7_alt: begin
                ok = (f3 == 3'd0) || (f3 == 3'd5);
                if (f3 == 3'd0)
                        op = word ? alu_subw : alu_sub;
                else
                        op = word ? alu_sraw : alu_sra;
        end
        f7_muldiv: begin
                ok = (f3 == 3'd0) || f3[2];   // no mulh forms
                case (f3)
                3'd0: op = word ? alu_mulw : alu_mul;
                3'd4: op = word ? alu_divw : alu_div;
                3'd5: op = word ? alu_divuw : alu_divu;
                3'd6: op = word ? alu_remw : alu_rem;
                default: op = word ? alu_remuw : alu_remu;
                endcase
        end
        default: ok = 1'b0;
        endcase
        return op;
endfunction

function automatic ctrl_t ref_decode(input inst_t w, input branch_flags_t f, output logic trap);
        ctrl_t      c;
        logic       ok;
        logic       word;
        logic       cond;
        logic [2:0] f3;
        logic [6:0] f7;
        c = ctrl_idle;
        ok = 1'b1;
        cond = 1'b0;
        f3 = w.r.funct3;
        f7 = w.r.funct7;
        word = (w.r.opcode == opc_op_32) || (w.r.opcode == opc_op_imm_32);
        case (w.r.opcode)
        opc_op, opc_op_32: begin
                c.alu_sel = reg_alu(f7, f3, word, ok);
                c.reg_wen = 1'b1;
        end
        opc_op_imm, opc_op_imm_32: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                        if (!word)
                                f7[0] = 1'b0;   // shamt[5]
                        c.alu_sel = reg_alu(f7, f3, word, ok);
                        ok = ok && (f7 != f7_muldiv);
                end else begin
                        c.alu_sel = reg_alu(f7_base, f3, word, ok);
                end
                c.alu_b_sel = alu_b_imm;
                c.reg_wen = 1'b1;
        end
        opc_load: begin
                ok = (f3 != 3'd7);
                c.mem_r_sel = mem_r_sel_e'(f3);
                c.alu_b_sel = alu_b_imm;
                c.mem_ren = 1'b1;
                c.reg_wen = 1'b1;
                c.reg_w_sel = reg_w_mem;
        end
        opc_store: begin
                ok = (f3 < 3'd4);
                c.mem_mask = 8'((9'd1 << (4'd1 << f3)) - 9'd1);   // 2**f3 bytes
                c.imm_sel = imm_s;
                c.alu_b_sel = alu_b_imm;
                c.mem_wen = 1'b1;
        end
        opc_branch: begin
                case (f3[2:1])
                2'b00: cond = f.eq;
                2'b10: cond = f.lt;
                2'b11: cond = f.ltu;
                default: ok = 1'b0;
                endcase
                cond = cond ^ f3[0];   // odd funct3 inverts
                c.imm_sel = imm_sb;
                c.alu_a_sel = alu_a_pc;
                c.alu_b_sel = alu_b_imm;
                c.pc_sel = cond ? pc_alu : pc_snpc;
        end
        opc_jal, opc_jalr: begin
                ok = (w.r.opcode == opc_jal) || (f3 == 3'd0);
                c.imm_sel = (w.r.opcode == opc_jal) ? imm_uj : imm_i;
                c.alu_a_sel = (w.r.opcode == opc_jal) ? alu_a_pc : alu_a_rs1;
                c.alu_b_sel = alu_b_imm;
                c.pc_sel = pc_alu;
                c.reg_wen = 1'b1;
                c.reg_w_sel = reg_w_pc;
        end
        opc_lui: begin
                c.imm_sel = imm_u;
                c.alu_a_sel = alu_a_zero;   // rd gets the immediate alone
                c.alu_b_sel = alu_b_imm;
                c.reg_wen = 1'b1;
        end
        opc_auipc: begin
                c.imm_sel = imm_u;
                c.alu_a_sel = alu_a_pc;
                c.alu_b_sel = alu_b_imm;
                c.reg_wen = 1'b1;
        end
        default: ok = 1'b0;   // system words and unknown opcodes trap
        endcase
        trap = !ok;
        if (!ok)
                c = ctrl_idle;
        return c;
endfunction

`endif

/* verification/tb_control.sv */
`timescale 1ns/100ps

module tb_control;
        import rv_isa_pkg::*;
        import ctrl_pkg::*;

        `include "control_ref.svh"

        localparam int clk_period_ns = 8;
        localparam int reset_cycles  = 8;
        localparam int stream_len    = 200;
        localparam int num_vectors   = 192 + 64 + 64 + 16 + 2 + 32 + stream_len;
        localparam int timeout_ns    = (num_vectors + reset_cycles + 32) * clk_period_ns;

        localparam opcode_e opc_tab [12] = '{opc_op, opc_op_32, opc_op_imm, opc_op_imm_32,
                                             opc_load, opc_store, opc_branch, opc_jal,
                                             opc_jalr, opc_lui, opc_auipc, opc_system};
        localparam opcode_e arith_opc [4] = '{opc_op, opc_op_32, opc_op_imm, opc_op_imm_32};
        localparam logic [6:0] f7_tab [3] = '{f7_base, f7_alt, f7_muldiv};

        logic          clk;
        logic          reset;
        inst_t         inst;
        branch_flags_t flags;
        ctrl_t         ctrl;
        logic          ebreak_flag;

        ctrl_t       exp_ctrl_q[$];
        logic        exp_flag_q[$];
        int          sent = 0;
        int          checked = 0;
        int          ctrl_errors = 0;
        int          flag_errors = 0;
        int          other_errors = 0;
        logic [31:0] lfsr_state = 32'h4648;

        tb_clock_gen #(
                .half_period  (clk_period_ns / 2),
                .reset_cycles (reset_cycles)
        ) clk_gen (
                .clk   (clk),
                .reset (reset)
        );

        control dut (
                .clk         (clk),
                .reset       (reset),
                .inst        (inst),
                .flags       (flags),
                .ctrl        (ctrl),
                .ebreak_flag (ebreak_flag)
        );

        // taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int k = 0; k < n; k++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        v = {v[30:0], lfsr_state[0]};
                end
                return v;
        endfunction

        function automatic inst_t u_form_word(input opcode_e opc);
                logic [31:0] v;
                v = take_bits(25);
                return inst_t'({v[24:0], opc});
        endfunction

        function automatic logic opcode_in_table(input logic [6:0] o);
                for (int k = 0; k < 12; k++)
                        if (o == opc_tab[k])
                                return 1'b1;
                return 1'b0;
        endfunction

        task automatic check_ctrl(input ctrl_t exp, input ctrl_t act);
                if (act !== exp) begin
                        ctrl_errors++;
                        $display("[FAIL] %0t ns ctrl expected %h actual %h", $time, exp, act);
                end
        endtask

        task automatic check_flag(input logic exp, input logic act);
                if (act !== exp) begin
                        flag_errors++;
                        $display("[FAIL] %0t ns ebreak_flag expected %b actual %b",
                                 $time, exp, act);
                end
        endtask

        // drive one word now, then move on to the next falling edge
        task automatic apply(input inst_t w, input branch_flags_t f);
                ctrl_t exp_c;
                logic  exp_f;
                inst = w;
                flags = f;
                exp_c = ref_decode(w, f, exp_f);
                exp_ctrl_q.push_back(exp_c);
                exp_flag_q.push_back(exp_f);
                sent++;
                @(negedge clk);
        endtask

        task automatic arith_sweep();
                int         o;
                int         f3;
                logic [6:0] f7;
                logic       imm_form;
                for (int n = 0; n < 192; n++) begin
                        o = (n / 24) % 4;
                        f3 = n % 8;
                        f7 = f7_tab[(n / 8) % 3];
                        imm_form = (arith_opc[o] == opc_op_imm) || (arith_opc[o] == opc_op_imm_32);
                        if (imm_form && f3 != 1 && f3 != 5)
                                f7 = 7'(take_bits(7));   // plain imm bits
                        else if (arith_opc[o] == opc_op_imm)
                                f7[0] = 1'(take_bits(1));
                        apply(r_word(f7, 5'(take_bits(5)), 5'(take_bits(5)), 3'(f3),
                                     5'(take_bits(5)), arith_opc[o]),
                              branch_flags_t'(3'(take_bits(3))));
                end
        endtask

        task automatic memory_sweep();
                inst_t w;
                for (int n = 0; n < 64; n++) begin
                        if (n % 16 < 8)
                                w = i_word(12'(take_bits(12)), 5'(take_bits(5)), 3'(n),
                                           5'(take_bits(5)), opc_load);
                        else
                                w = r_word(7'(take_bits(7)), 5'(take_bits(5)), 5'(take_bits(5)),
                                           3'(n), 5'(take_bits(5)), opc_store);
                        apply(w, branch_flags_t'(3'(take_bits(3))));
                end
        endtask

        task automatic flow_sweep();
                inst_t w;
                for (int n = 0; n < 64; n++) begin
                        w = r_word(7'(take_bits(7)), 5'(take_bits(5)), 5'(take_bits(5)),
                                   3'(n / 8), 5'(take_bits(5)), opc_branch);
                        apply(w, branch_flags_t'(3'(n)));   // every flag combination
                end
                for (int n = 0; n < 16; n++) begin
                        case (n % 4)
                        0: w = u_form_word(opc_jal);
                        1: w = i_word(12'(take_bits(12)), 5'(take_bits(5)), 3'd0,
                                      5'(take_bits(5)), opc_jalr);
                        2: w = u_form_word(opc_lui);
                        default: w = u_form_word(opc_auipc);
                        endcase
                        apply(w, branch_flags_t'(3'(take_bits(3))));
                end
        endtask

        task automatic trap_words();
                logic [6:0]  o;
                logic [31:0] v;
                apply(i_word(ebreak_imm, 5'd0, 3'd0, 5'd0, opc_system), '0);
                apply(i_word(12'h000, 5'd0, 3'd0, 5'd0, opc_system), '0);   // ecall
                for (int n = 0; n < 32; n++) begin
                        do
                                o = 7'(take_bits(7));
                        while (opcode_in_table(o));
                        v = take_bits(25);
                        apply(inst_t'({v[24:0], o}), branch_flags_t'(3'(take_bits(3))));
                end
        endtask

        task automatic random_stream();
                logic [31:0] v;
                logic [3:0]  sel;
                for (int n = 0; n < stream_len; n++) begin
                        v = take_bits(32);
                        sel = 4'(take_bits(4));
                        if (sel < 4'd12)
                                v[6:0] = opc_tab[sel];
                        case (2'(take_bits(2)))
                        2'd0: v[31:25] = f7_base;
                        2'd1: v[31:25] = f7_alt;
                        2'd2: v[31:25] = f7_muldiv;
                        default: ;   // random funct7
                        endcase
                        apply(inst_t'(v), branch_flags_t'(3'(take_bits(3))));
                end
        endtask

        initial begin : compare_outputs
                logic  in_reset;
                ctrl_t exp_c;
                logic  exp_f;
                forever begin
                        @(posedge clk);
                        in_reset = reset;
                        #1;
                        if (in_reset) begin
                                check_ctrl(ctrl_idle, ctrl);
                                check_flag(1'b0, ebreak_flag);
                        end else if (exp_ctrl_q.size() > 0) begin
                                exp_c = exp_ctrl_q.pop_front();
                                exp_f = exp_flag_q.pop_front();
                                check_ctrl(exp_c, ctrl);
                                check_flag(exp_f, ebreak_flag);
                                checked++;
                        end
                end
        end

        initial begin : watchdog
                #(timeout_ns);
                $display("timeout after %0d ns, the DUT did not finish all vectors", timeout_ns);
                $display("Simulation failed");
                $finish;
        end

        initial begin : stimulus
                inst = i_word(ebreak_imm, 5'd0, 3'd0, 5'd0, opc_system);   // would trap outside reset
                flags = '0;
                @(negedge reset);
                arith_sweep();
                memory_sweep();
                flow_sweep();
                trap_words();
                random_stream();
                while (exp_ctrl_q.size() != 0)
                        @(posedge clk);
                #2;
                if (checked != sent) begin
                        other_errors++;
                        $display("only %0d of %0d results were compared", checked, sent);
                end
                $display("errors: ctrl %0d, ebreak_flag %0d, other %0d over %0d vectors",
                         ctrl_errors, flag_errors, other_errors, sent);
                if (ctrl_errors + flag_errors + other_errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

/* compile.f */
+incdir+verification
rtl/rv_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/alu_op_decode.sv
rtl/mem_op_decode.sv
rtl/flow_op_decode.sv
rtl/ctrl_stage_reg.sv
rtl/control.sv
verification/tb_clock_gen.sv
verification/tb_control.sv

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module tb_control \
        -o sim_control --Mdir obj_dir > build.log 2>&1 \
        && ./obj_dir/sim_control > sim.log 2>&1 \
        || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
